/* Makefile */
VERILATOR ?= verilator
TOP ?= uf_decoder_tb
FILELIST ?= uf_decoder.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing
PASS_MESSAGE ?= Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MESSAGE)"

clean:
	rm -rf $(BUILD_DIR)

/* bench/uf_decoder_tb.sv */
`default_nettype none

module uf_decoder_tb import uf_pkg::*; ();
    localparam int TIMEOUT_CYCLES = 1000;
    localparam int RANDOM_COUNT = 40;
    localparam int HOLD_CYCLES = 20;

    logic                     clk;
    logic                     reset;
    logic                     in_valid;
    logic                     in_ready;
    logic [ANCILLA_COUNT-1:0] in_syndrome;
    logic                     out_valid;
    logic                     out_ready;
    logic [DISTANCE-1:0]      out_correction;

    integer seed = 32'h0d15f3d2;
    int     mismatch_count = 0;
    int     timeout_count = 0;
    int     queued = 0;
    int     received = 0;

    // Outstanding cases, oldest first
    logic [ANCILLA_COUNT-1:0] exp_syndrome [$];
    logic [DISTANCE-1:0]      exp_correction [$];
    logic                     exp_exact [$];
    string                    exp_name [$];

    uf_decoder dut0 (
        .clk, .reset, .in_valid, .in_ready, .in_syndrome,
        .out_valid, .out_ready, .out_correction
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Ancilla i compares data qubits i and i+1
    function automatic logic [ANCILLA_COUNT-1:0] expected_syndrome(
        input logic [DISTANCE-1:0] correction
    );
        logic [ANCILLA_COUNT-1:0] result;
        for (int i = 0; i < ANCILLA_COUNT; i++) begin
            result[i] = correction[i] ^ correction[i+1];
        end
        return result;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic queue_case(input string name, input logic [ANCILLA_COUNT-1:0] syndrome,
                              input logic [DISTANCE-1:0] correction, input logic exact);
        exp_name.push_back(name);
        exp_syndrome.push_back(syndrome);
        exp_correction.push_back(correction);
        exp_exact.push_back(exact);
        queued++;
    endtask

    // Starts and ends on a falling edge
    task automatic send_syndrome(input logic [ANCILLA_COUNT-1:0] syndrome);
        int waited;
        waited = 0;
        in_valid = 1'b1;
        in_syndrome = syndrome;
        @(posedge clk);
        while (!in_ready && waited < TIMEOUT_CYCLES) begin
            waited++;
            @(posedge clk);
        end
        if (!in_ready) begin
            $display("Decoder never accepted syndrome %b", syndrome);
            timeout_count++;
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_for_results(input int target);
        int waited;
        waited = 0;
        while (received < target && waited < TIMEOUT_CYCLES) begin
            waited++;
            @(negedge clk);
        end
        if (received < target) begin
            $display("No correction arrived for case %0d in time", target);
            timeout_count++;
        end
    endtask

    task automatic run_case(input string name, input logic [ANCILLA_COUNT-1:0] syndrome,
                            input logic [DISTANCE-1:0] correction, input logic exact);
        queue_case(name, syndrome, correction, exact);
        send_syndrome(syndrome);
        wait_for_results(queued);
    endtask

    initial begin : compare_results
        string                    name;
        logic [ANCILLA_COUNT-1:0] want_syndrome;
        logic [DISTANCE-1:0]      want_correction;
        logic                     exact;
        forever begin
            @(posedge clk);
            if (!reset && out_valid && out_ready) begin
                if (exp_name.size() == 0) begin
                    $display("Correction %b arrived with no syndrome outstanding",
                             out_correction);
                    mismatch_count++;
                end else begin
                    name = exp_name.pop_front();
                    want_syndrome = exp_syndrome.pop_front();
                    want_correction = exp_correction.pop_front();
                    exact = exp_exact.pop_front();
                    compare_value({name, "_syndrome"}, 32'(want_syndrome),
                                  32'(expected_syndrome(out_correction)));
                    if (exact) begin
                        compare_value({name, "_correction"}, 32'(want_correction),
                                      32'(out_correction));
                    end
                end
                received++;
            end
        end
    end

    initial begin : stimulus
        logic [DISTANCE-1:0]      one_hot;
        logic [DISTANCE-1:0]      held_correction;
        logic [31:0]              random_word;
        logic [ANCILLA_COUNT-1:0] random_syndrome;
        int                       waited;
        reset = 1'b1;
        in_valid = 1'b0;
        in_syndrome = '0;
        out_ready = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        compare_value("reset_in_ready", 32'd1, 32'(in_ready));
        compare_value("reset_out_valid", 32'd0, 32'(out_valid));

        run_case("zero_syndrome", '0, '0, 1'b1);

        for (int p = 0; p < DISTANCE; p++) begin
            one_hot = '0;
            one_hot[p] = 1'b1;
            run_case($sformatf("single_error_%0d", p), expected_syndrome(one_hot), one_hot, 1'b1);
        end

        for (int k = 0; k < RANDOM_COUNT; k++) begin
            random_word = $random(seed);
            random_syndrome = random_word[ANCILLA_COUNT-1:0];
            run_case($sformatf("random_%0d", k), random_syndrome, '0, 1'b0);
        end

        // Hold the result back and watch it stay put
        random_word = $random(seed);
        random_syndrome = random_word[ANCILLA_COUNT-1:0];
        out_ready = 1'b0;
        queue_case("backpressure", random_syndrome, '0, 1'b0);
        send_syndrome(random_syndrome);
        waited = 0;
        while (!out_valid && waited < TIMEOUT_CYCLES) begin
            waited++;
            @(negedge clk);
        end
        if (!out_valid) begin
            $display("Correction never became valid under back-pressure");
            timeout_count++;
        end
        held_correction = out_correction;
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            compare_value("backpressure_hold", 32'(held_correction), 32'(out_correction));
            compare_value("backpressure_in_ready", 32'd0, 32'(in_ready));
        end
        out_ready = 1'b1;
        wait_for_results(queued);

        $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* common/uf_pkg.sv */
`default_nettype none

package uf_pkg;

    localparam int DISTANCE = 7;                  // Data qubits, one edge each
    localparam int ANCILLA_COUNT = DISTANCE - 1;
    localparam int ADDRESS_WIDTH = 3;

    // Enough rounds for a lone defect in the middle of the line to reach a boundary
    localparam int MAX_GROW_ROUNDS = 8;
    localparam int ROUND_COUNT_WIDTH = 4;

    typedef enum logic [2:0] {
        STAGE_IDLE   = 3'd0,
        STAGE_LOAD   = 3'd1,
        STAGE_GROW   = 3'd2,
        STAGE_MERGE  = 3'd3,
        STAGE_PEEL   = 3'd4,
        STAGE_RESULT = 3'd5
    } stage_t;

    // What one unit shows its neighbors
    typedef struct packed {
        logic [ADDRESS_WIDTH-1:0] root;
        logic                     is_parent;          // Sender's parent is on its low side
        logic                     odd_to_child;
        logic                     cluster_parity;
        logic                     touching_boundary;
        logic                     peeling_complete;
        logic                     peeling_m;
        logic                     peeling_parity_completed;
    } pe_link_t;

endpackage

`default_nettype wire

/* processing_unit/min_root_select.sv */
`default_nettype none

module min_root_select import uf_pkg::*; (
    input  logic [ADDRESS_WIDTH-1:0] values [2],
    input  logic [1:0]               valids,
    output logic [ADDRESS_WIDTH-1:0] result,
    output logic [1:0]               output_valids
);

    // Side 0 wins a tie
    always_comb begin
        if (valids[0] && (!valids[1] || values[0] <= values[1])) begin
            result = values[0];
            output_valids = 2'b01;
        end else if (valids[1]) begin
            result = values[1];
            output_valids = 2'b10;
        end else begin
            result = '1;                 // Nothing valid
            output_valids = 2'b00;
        end
    end

endmodule

`default_nettype wire

/* processing_unit/processing_unit.sv */
`default_nettype none

module processing_unit import uf_pkg::*; #(
    parameter int         ADDRESS = 0,
    parameter logic [1:0] BOUNDARY_SIDES = 2'b00
) (
    input  logic     clk,
    input  logic     reset,
    input  stage_t   stage,
    input  logic     measurement,
    input  pe_link_t link_in [2],
    output pe_link_t link_out,
    input  logic [1:0] neighbor_fully_grown,
    output logic     neighbor_increase,
    output logic [1:0] neighbor_is_error,
    output logic     odd,
    output logic     busy
);
    stage_t                   unit_stage;
    logic                     m;
    logic [ADDRESS_WIDTH-1:0] root;
    logic [1:0]               parent_vector;
    logic                     odd_to_child;
    logic                     cluster_parity;
    logic                     touching_boundary;
    logic                     peeling_complete;
    logic                     peeling_m;
    logic                     parity_completed;

    logic [ADDRESS_WIDTH-1:0] neighbor_root [2];
    logic [1:0] child_vector, child_parity, child_touch, child_done, child_m;
    logic [1:0] parent_odd, parent_done;
    logic [ADDRESS_WIDTH-1:0] sel_root;
    logic [1:0] sel_valids;
    logic boundary_reached, has_parent, adopt;
    logic next_parity, next_touch, next_odd, merge_change;
    logic carry, not_complete, peel_active;

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            neighbor_root[s] = link_in[s].root;
            child_parity[s] = link_in[s].cluster_parity;
            child_touch[s] = link_in[s].touching_boundary;
            child_done[s] = link_in[s].peeling_complete;
            child_m[s] = link_in[s].peeling_m;
            parent_odd[s] = link_in[s].odd_to_child;
            parent_done[s] = link_in[s].peeling_parity_completed;
        end
    end

    // Roots shrink toward low addresses, so only the right neighbor can be a child
    assign child_vector = {link_in[1].is_parent & ~BOUNDARY_SIDES[1], 1'b0};

    min_root_select root_select (
        .values        (neighbor_root),
        .valids        (neighbor_fully_grown & ~BOUNDARY_SIDES),
        .result        (sel_root),
        .output_valids (sel_valids)
    );

    assign boundary_reached = |(neighbor_fully_grown & BOUNDARY_SIDES);
    assign has_parent = |parent_vector;
    assign adopt = (|sel_valids) && (sel_root < root);
    assign next_parity = m ^ (^(child_vector & child_parity));
    assign next_touch = boundary_reached | (|(child_vector & child_touch));
    assign next_odd = has_parent ? |(parent_vector & parent_odd) : next_parity & ~next_touch;
    assign merge_change = adopt || next_parity != cluster_parity ||
                          next_touch != touching_boundary || next_odd != odd;

    // Defect carried down from the root while peeling
    assign carry = has_parent ? |(parent_vector & parent_odd) : cluster_parity;
    assign not_complete = (|(child_vector & ~child_done)) | ~parity_completed;
    assign peel_active = (unit_stage == STAGE_PEEL) && !not_complete;

    assign neighbor_increase = odd && unit_stage == STAGE_GROW;   // GROW lasts one cycle
    assign neighbor_is_error = peel_active ?
                               (child_vector & child_m) | (odd ? BOUNDARY_SIDES : 2'b00) : 2'b00;

    assign link_out = '{root: root, is_parent: parent_vector[0], odd_to_child: odd_to_child,
                        cluster_parity: cluster_parity, touching_boundary: touching_boundary,
                        peeling_complete: peeling_complete, peeling_m: peeling_m,
                        peeling_parity_completed: parity_completed};

    always_ff @(posedge clk) begin
        if (reset) begin
            unit_stage <= STAGE_IDLE;
            parent_vector <= 2'b00;
            odd <= 1'b0;
            odd_to_child <= 1'b0;
            parity_completed <= 1'b0;
            peeling_complete <= 1'b0;
            busy <= 1'b0;
        end else begin
            unit_stage <= stage;
            busy <= 1'b0;
            case (unit_stage)
                STAGE_LOAD: begin
                    parent_vector <= 2'b00;
                    odd <= measurement;
                    odd_to_child <= measurement;
                    parity_completed <= 1'b0;
                    peeling_complete <= 1'b0;
                end
                STAGE_MERGE: begin
                    if (adopt) parent_vector <= sel_valids;
                    odd <= next_odd;
                    odd_to_child <= next_odd;
                    busy <= merge_change;
                end
                STAGE_PEEL: begin
                    odd <= carry & boundary_reached;     // This unit absorbs the defect
                    odd_to_child <= carry & ~boundary_reached & (|(child_vector & child_touch));
                    parity_completed <= has_parent ? |(parent_vector & parent_done) : 1'b1;
                    peeling_complete <= !not_complete;
                    busy <= not_complete;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (unit_stage == STAGE_LOAD) begin
            m <= measurement;
            root <= ADDRESS_WIDTH'(ADDRESS);
            cluster_parity <= measurement;
            touching_boundary <= 1'b0;
            peeling_m <= 1'b0;
        end else if (unit_stage == STAGE_MERGE) begin
            if (adopt) root <= sel_root;
            cluster_parity <= next_parity;
            touching_boundary <= next_touch;
        end else if (peel_active) begin
            peeling_m <= m ^ (^(child_vector & child_m)) ^ odd;
        end
    end

endmodule

`default_nettype wire

/* uf_decoder.f */
common/uf_pkg.sv
verilog/syndrome_loader.sv
verilog/stage_controller.sv
processing_unit/min_root_select.sv
processing_unit/processing_unit.sv
verilog/edge_tracker.sv
verilog/correction_sender.sv
verilog/uf_decoder.sv
bench/uf_decoder_tb.sv

/* verilog/correction_sender.sv */
`default_nettype none

module correction_sender import uf_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  stage_t              stage,
    input  logic [DISTANCE-1:0] edge_error,
    output logic                out_free,
    output logic                out_valid,
    input  logic                out_ready,
    output logic [DISTANCE-1:0] out_correction
);
    logic full;
    logic capture;

    assign capture = (stage == STAGE_RESULT) && !full;
    assign out_valid = full;
    assign out_free = !full || out_ready;   // Empty now or emptied this cycle

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (capture) begin
            full <= 1'b1;
        end else if (out_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            out_correction <= edge_error;
        end
    end

endmodule

`default_nettype wire

/* verilog/edge_tracker.sv */
`default_nettype none

module edge_tracker import uf_pkg::*; #(
    parameter int SIDES = 2
) (
    input  logic             clk,
    input  logic             reset,
    input  stage_t           stage,
    input  logic [SIDES-1:0] increase,
    input  logic [SIDES-1:0] error_mark,
    output logic             fully_grown,
    output logic             is_error
);
    logic [1:0] count;
    logic [2:0] sum;

    assign fully_grown = (count == 2'd2);

    always_comb begin
        sum = {1'b0, count};
        for (int s = 0; s < SIDES; s++) begin
            sum = sum + {2'b00, increase[s]};   // One step per asserting side
        end
    end

    always_ff @(posedge clk) begin
        if (reset || stage == STAGE_LOAD) begin
            count <= 2'd0;
            is_error <= 1'b0;
        end else begin
            count <= (sum >= 3'd2) ? 2'd2 : sum[1:0];
            if (stage == STAGE_PEEL && |error_mark) begin
                is_error <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/stage_controller.sv */
`default_nettype none

module stage_controller import uf_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   syndrome_valid,
    output logic   syndrome_take,
    input  logic   any_busy,
    input  logic   any_odd,
    input  logic   out_free,
    output stage_t stage
);
    stage_t                       stage_next;
    logic [1:0]                   dwell;     // Cycles spent in the current stage, saturating
    logic [1:0]                   quiet;     // Consecutive cycles with no busy unit
    logic [1:0]                   quiet_next;
    logic [ROUND_COUNT_WIDTH-1:0] rounds;
    logic                         settled;

    assign syndrome_take = (stage == STAGE_LOAD);
    assign settled = (quiet == 2'd2);

    // Busy lags the stage by two cycles, so the first two cycles do not count
    always_comb begin
        if (!any_busy && dwell >= 2'd2) begin
            quiet_next = settled ? quiet : quiet + 2'd1;
        end else begin
            quiet_next = 2'd0;
        end
    end

    always_comb begin
        stage_next = stage;
        case (stage)
            STAGE_IDLE:   if (syndrome_valid) stage_next = STAGE_LOAD;
            STAGE_LOAD:   stage_next = STAGE_GROW;
            STAGE_GROW:   stage_next = STAGE_MERGE;
            STAGE_MERGE: begin
                if (settled) begin
                    if (any_odd && rounds < MAX_GROW_ROUNDS) begin
                        stage_next = STAGE_GROW;
                    end else begin
                        stage_next = STAGE_PEEL;   // Even everywhere, or out of rounds
                    end
                end
            end
            STAGE_PEEL:   if (settled) stage_next = STAGE_RESULT;
            STAGE_RESULT: if (dwell != 2'd0 && out_free) stage_next = STAGE_IDLE;
            default:      stage_next = STAGE_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= STAGE_IDLE;
            dwell <= 2'd0;
            quiet <= 2'd0;
            rounds <= '0;
        end else begin
            stage <= stage_next;
            if (stage_next != stage) begin
                dwell <= 2'd0;
                quiet <= 2'd0;
            end else begin
                dwell <= (dwell == 2'd3) ? dwell : dwell + 2'd1;
                quiet <= quiet_next;
            end
            if (stage == STAGE_LOAD) begin
                rounds <= '0;
            end else if (stage == STAGE_GROW) begin
                rounds <= rounds + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/syndrome_loader.sv */
`default_nettype none

module syndrome_loader import uf_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic [ANCILLA_COUNT-1:0] in_syndrome,
    input  stage_t                   stage,
    input  logic                     syndrome_take,
    output logic                     syndrome_valid,
    output logic [ANCILLA_COUNT-1:0] syndrome
);
    logic held;

    assign in_ready = (stage == STAGE_IDLE) && !held;
    assign syndrome_valid = held;

    always_ff @(posedge clk) begin
        if (reset) begin
            held <= 1'b0;
        end else if (in_valid && in_ready) begin
            held <= 1'b1;
        end else if (syndrome_take) begin
            held <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            syndrome <= in_syndrome;
        end
    end

endmodule

`default_nettype wire

/* verilog/uf_decoder.sv */
`default_nettype none

module uf_decoder import uf_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic [ANCILLA_COUNT-1:0] in_syndrome,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic [DISTANCE-1:0]      out_correction
);
    stage_t                   stage;
    logic                     syndrome_valid, syndrome_take, out_free;
    logic [ANCILLA_COUNT-1:0] syndrome, unit_increase, unit_odd, unit_busy;
    logic [1:0]               unit_error [ANCILLA_COUNT];
    pe_link_t                 unit_link [ANCILLA_COUNT];
    logic [DISTANCE-1:0]      edge_grown, edge_error;

    syndrome_loader loader (
        .clk, .reset, .in_valid, .in_ready, .in_syndrome, .stage,
        .syndrome_take, .syndrome_valid, .syndrome
    );

    stage_controller controller (
        .clk, .reset, .syndrome_valid, .syndrome_take,
        .any_busy(|unit_busy), .any_odd(|unit_odd), .out_free, .stage
    );

    // Unit i sits between edge i on side 0 and edge i+1 on side 1
    for (genvar i = 0; i < ANCILLA_COUNT; i++) begin : unit
        localparam int LEFT = (i == 0) ? 0 : i - 1;
        localparam int RIGHT = (i == ANCILLA_COUNT - 1) ? i : i + 1;
        pe_link_t link_in [2];
        assign link_in[0] = unit_link[LEFT];
        assign link_in[1] = unit_link[RIGHT];

        processing_unit #(
            .ADDRESS(i),
            .BOUNDARY_SIDES({i == ANCILLA_COUNT - 1, i == 0})
        ) pu (
            .clk, .reset, .stage, .measurement(syndrome[i]),
            .link_in(link_in), .link_out(unit_link[i]),
            .neighbor_fully_grown(edge_grown[i+1:i]), .neighbor_increase(unit_increase[i]),
            .neighbor_is_error(unit_error[i]), .odd(unit_odd[i]), .busy(unit_busy[i])
        );
    end

    edge_tracker #(.SIDES(1)) edge_left (
        .clk, .reset, .stage, .increase(unit_increase[0]), .error_mark(unit_error[0][0]),
        .fully_grown(edge_grown[0]), .is_error(edge_error[0])
    );

    for (genvar j = 1; j < DISTANCE - 1; j++) begin : inner
        edge_tracker #(.SIDES(2)) et (
            .clk, .reset, .stage,
            .increase({unit_increase[j], unit_increase[j-1]}),
            .error_mark({unit_error[j][0], unit_error[j-1][1]}),
            .fully_grown(edge_grown[j]), .is_error(edge_error[j])
        );
    end

    edge_tracker #(.SIDES(1)) edge_right (
        .clk, .reset, .stage, .increase(unit_increase[ANCILLA_COUNT-1]),
        .error_mark(unit_error[ANCILLA_COUNT-1][1]),
        .fully_grown(edge_grown[DISTANCE-1]), .is_error(edge_error[DISTANCE-1])
    );

    correction_sender sender (
        .clk, .reset, .stage, .edge_error, .out_free, .out_valid, .out_ready, .out_correction
    );

endmodule

`default_nettype wire
